/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = fetch_tb
FILELIST = verilog.f

BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Result: PASSED

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb;

    localparam int PROG_WORDS    = 64;
    localparam int VALID_TIMEOUT = 100;
    // longer than any miss already in flight when stall rises
    localparam int STALL_LIMIT   = 24;

    logic                 clk;
    logic                 reset_n;
    logic                 prog_we;
    mem_pkg::load_addr_t  prog_addr;
    mem_pkg::mem_word_t   prog_data;
    logic                 stall;
    logic                 redirect;
    mem_pkg::mem_addr_t   redirect_pc;
    logic                 instr_valid;
    mem_pkg::mem_word_t   instr;
    mem_pkg::mem_addr_t   instr_pc;
    logic                 hit;
    logic                 miss;

    // reference copy of the loaded program
    mem_pkg::mem_word_t     model [PROG_WORDS];

    // expected state, updated at each rising edge
    cache_pkg::word_addr_t  exp_pc;
    logic                   last_was_miss;
    int                     stall_cycles;

    // armed by the stimulus for checks that hold only in some tests
    logic                   cold_run;
    logic                   miss_check_on;
    cache_pkg::word_addr_t  miss_check_pc;

    int fail_count = 0;
    int timeout_count;
    int tests_run;

    fetch_top fetch_top_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .hit         (hit),
        .miss        (miss)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset_n) begin
            exp_pc        <= '0;
            last_was_miss <= 1'b0;
            stall_cycles  <= 0;
        end else begin
            // a redirect wins over the word delivered in the same cycle
            if (redirect) begin
                exp_pc <= redirect_pc;
            end else if (instr_valid) begin
                exp_pc <= exp_pc + 16'd1;
            end
            if (miss) begin
                last_was_miss <= 1'b1;
            end else if (hit) begin
                last_was_miss <= 1'b0;
            end
            if (stall) begin
                stall_cycles <= stall_cycles + 1;
            end else begin
                stall_cycles <= 0;
            end
        end
    end

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        fail_count++;
        $display("FAIL %s expected 0x%0h actual 0x%0h", test, expected, actual);
    endtask

    pc_order: assert property (
        @(posedge clk) disable iff (reset_n)
        instr_valid |-> (instr_pc == exp_pc)
    ) else report_mismatch("pc_order", 32'($sampled(exp_pc)), 32'($sampled(instr_pc)));

    data_match: assert property (
        @(posedge clk) disable iff (reset_n)
        instr_valid |-> (instr == model[instr_pc[5:0]])
    ) else report_mismatch("data_match", 32'(model[$sampled(instr_pc[5:0])]),
                           32'($sampled(instr)));

    // cold straight-line code misses on offset 0 only
    fill_pattern: assert property (
        @(posedge clk) disable iff (reset_n)
        (instr_valid && cold_run) |-> (last_was_miss == (instr_pc[1:0] == 2'd0))
    ) else report_mismatch("fill_pattern", 32'($sampled(instr_pc[1:0]) == 2'd0),
                           32'($sampled(last_was_miss)));

    forced_miss: assert property (
        @(posedge clk) disable iff (reset_n)
        (instr_valid && miss_check_on && instr_pc == miss_check_pc) |-> last_was_miss
    ) else report_mismatch("forced_miss", 32'd1, 32'($sampled(last_was_miss)));

    stall_hold: assert property (
        @(posedge clk) disable iff (reset_n)
        (stall_cycles > STALL_LIMIT) |-> !instr_valid
    ) else report_mismatch("stall_hold", 32'd0, 32'($sampled(instr_valid)));

    // lookup, done, then delivery unless a redirect drops the word
    hit_latency: assert property (
        @(posedge clk) disable iff (reset_n)
        ($past(hit, 2) && !$past(redirect, 2) && !$past(redirect, 1)) |-> instr_valid
    ) else report_mismatch("hit_latency", 32'd1, 32'($sampled(instr_valid)));

    task automatic apply_reset(input bit load_program);
        reset_n = 1'b1;
        if (load_program) begin
            for (int a = 0; a < PROG_WORDS; a++) begin
                @(negedge clk);
                prog_we   = 1'b1;
                prog_addr = mem_pkg::load_addr_t'(a);
                prog_data = model[a];
            end
            @(negedge clk);
            prog_we = 1'b0;
        end
        // hold reset a few cycles past the load
        repeat (4) @(negedge clk);
        reset_n = 1'b0;
    endtask

    // returns one negedge after the pulse, so a pulse is seen once
    task automatic wait_valid(input string what);
        int n;
        n = 0;
        while (!instr_valid && n < VALID_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!instr_valid) begin
            timeout_count++;
            $display("timeout: no instruction delivered while waiting for %s", what);
        end
        @(negedge clk);
    endtask

    task automatic wait_valids(input int count, input string what);
        repeat (count) wait_valid(what);
    endtask

    task automatic send_redirect(input cache_pkg::word_addr_t target, input bit want_miss);
        redirect      = 1'b1;
        redirect_pc   = target;
        miss_check_pc = target;
        miss_check_on = want_miss;
        @(negedge clk);
        redirect = 1'b0;
        wait_valid("redirect target");
        miss_check_on = 1'b0;
    endtask

    task automatic close_test(input string name, input int errors_before);
        int new_errors;
        new_errors = fail_count + timeout_count - errors_before;
        tests_run++;
        if (new_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, new_errors);
        end
    endtask

    initial begin
        int errors_before;
        int delay;
        int errors;
        reset_n       = 1'b1;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        stall         = 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        cold_run      = 1'b0;
        miss_check_on = 1'b0;
        miss_check_pc = '0;
        timeout_count = 0;
        tests_run     = 0;
        void'($urandom(32'he881));
        for (int a = 0; a < PROG_WORDS; a++) begin
            model[a] = mem_pkg::mem_word_t'($urandom);
        end
        apply_reset(1'b1);

        errors_before = fail_count + timeout_count;
        cold_run = 1'b1;
        wait_valids(12, "sequential fetch");
        close_test("sequential_fetch", errors_before);

        errors_before = fail_count + timeout_count;
        wait_valids(12, "block fill");
        cold_run = 1'b0;
        close_test("block_fill", errors_before);

        // set 0 holds the block at 16 now, so 0 misses first
        errors_before = fail_count + timeout_count;
        send_redirect(16'd0, 1'b1);
        wait_valids(2, "fetch after address 0");
        send_redirect(16'd16, 1'b1);
        send_redirect(16'd0, 1'b1);
        wait_valids(2, "fetch after eviction");
        close_test("conflict_eviction", errors_before);

        errors_before = fail_count + timeout_count;
        repeat (4) begin
            wait_valid("fetch before redirect");
            delay = $urandom_range(0, 6);
            repeat (delay) @(negedge clk);
            send_redirect(cache_pkg::word_addr_t'($urandom_range(0, 40)), 1'b0);
        end
        close_test("redirect", errors_before);

        errors_before = fail_count + timeout_count;
        wait_valid("fetch before stall");
        delay = $urandom_range(0, 3);
        repeat (delay) @(negedge clk);
        stall = 1'b1;
        repeat (40) @(negedge clk);
        stall = 1'b0;
        wait_valids(4, "fetch after stall");
        close_test("stall", errors_before);

        // cache must come back cold after a second reset
        errors_before = fail_count + timeout_count;
        miss_check_pc = '0;
        miss_check_on = 1'b1;
        apply_reset(1'b0);
        wait_valid("first fetch after reset");
        miss_check_on = 1'b0;
        wait_valids(6, "hits after reset");
        close_test("hit_timing_reset", errors_before);

        errors = fail_count + timeout_count;
        $display("tests %0d, check failures %0d, timeouts %0d",
                 tests_run, fail_count, timeout_count);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* src/cache_pkg.sv */
`include "fetch_consts.svh"

package cache_pkg;

    // full word address as seen by the fetch unit
    typedef logic [`WORD_SIZE-1:0] word_addr_t;

    // address fields, msb to lsb: tag, set, offset
    typedef logic [`TAG_SIZE-1:0] tag_t;
    typedef logic [$clog2(`NUM_SETS)-1:0] set_idx_t;
    typedef logic [$clog2(`BLOCK_WORDS)-1:0] offset_t;

    // one cached word with its own tag and valid bit
    typedef struct packed {
        logic valid;
        tag_t tag;
        logic [`WORD_SIZE-1:0] word;
    } line_t;

    // lookup is a phase, seen while idle with a request present
    typedef enum logic [1:0] {
        idle,
        lookup,
        fill,
        respond
    } fill_state_t;

endpackage

/* src/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// instruction word and address width
`define WORD_SIZE 16

// tag bits left over after set index and word offset
`define TAG_SIZE 12

// cache geometry, direct mapped
`define NUM_SETS 4
`define BLOCK_WORDS 4

// instruction memory size in words
`define MEM_DEPTH 256

// cycles from read strobe to read valid
`define MEM_LATENCY 3

`endif

/* src/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top (
    input  logic                 clk,
    input  logic                 reset_n,

    // program load
    input  logic                 prog_we,
    input  mem_pkg::load_addr_t  prog_addr,
    input  mem_pkg::mem_word_t   prog_data,

    // decode stage controls
    input  logic                 stall,
    input  logic                 redirect,
    input  mem_pkg::mem_addr_t   redirect_pc,

    // fetched instruction
    output logic                 instr_valid,
    output mem_pkg::mem_word_t   instr,
    output mem_pkg::mem_addr_t   instr_pc,

    // cache lookup result
    output logic                 hit,
    output logic                 miss
);

    // fetch unit to cache
    logic                fetch_req;
    mem_pkg::mem_addr_t  fetch_addr;
    logic                done;
    mem_pkg::mem_word_t  rd_data;

    // cache to memory
    logic                mem_rd;
    mem_pkg::mem_addr_t  mem_addr;
    logic                mem_valid;
    mem_pkg::mem_word_t  mem_data;

    fetch_unit fetch_unit_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .done        (done),
        .rd_data     (rd_data),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

    icache icache_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .done       (done),
        .rd_data    (rd_data),
        .mem_rd     (mem_rd),
        .mem_addr   (mem_addr),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data),
        .hit        (hit),
        .miss       (miss)
    );

    inst_mem inst_mem_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .mem_rd    (mem_rd),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_data  (mem_data)
    );

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic                   clk,
    input  logic                   reset_n,

    // from the decode stage
    input  logic                   stall,
    input  logic                   redirect,
    input  cache_pkg::word_addr_t  redirect_pc,

    // cache request
    output logic                   fetch_req,
    output cache_pkg::word_addr_t  fetch_addr,
    input  logic                   done,
    input  mem_pkg::mem_word_t     rd_data,

    // delivered instruction
    output logic                   instr_valid,
    output mem_pkg::mem_word_t     instr,
    output cache_pkg::word_addr_t  instr_pc
);

    cache_pkg::word_addr_t  pc;

    // redirect seen while a request was in flight
    logic                   redir_pend;
    cache_pkg::word_addr_t  redir_target;

    assign fetch_addr = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc           <= '0;
            fetch_req    <= 1'b0;
            redir_pend   <= 1'b0;
            redir_target <= '0;
            instr_valid  <= 1'b0;
            instr        <= '0;
            instr_pc     <= '0;
        end else begin
            // outputs are pulses, low unless delivering
            instr_valid <= 1'b0;
            instr       <= '0;
            instr_pc    <= '0;
            if (fetch_req) begin
                if (done) begin
                    fetch_req  <= 1'b0;
                    redir_pend <= 1'b0;
                    if (redirect) begin
                        pc <= redirect_pc;
                    end else if (redir_pend) begin
                        pc <= redir_target;
                    end else begin
                        instr_valid <= 1'b1;
                        instr       <= rd_data;
                        instr_pc    <= pc;
                        pc          <= pc + cache_pkg::word_addr_t'(1);
                    end
                end else if (redirect) begin
                    // let the request finish, drop its word later
                    redir_pend   <= 1'b1;
                    redir_target <= redirect_pc;
                end
            end else begin
                if (redirect) begin
                    pc <= redirect_pc;
                end
                if (!stall) begin
                    fetch_req <= 1'b1;
                end
            end
        end
    end

    // cache samples the address over the whole request
    addr_stable_in_req: assert property (
        @(posedge clk) disable iff (reset_n)
        (fetch_req && !done) |=> $stable(fetch_addr)
    );

endmodule

/* src/icache.sv */
`timescale 1ns/10ps

`include "fetch_consts.svh"

module icache (
    input  logic                   clk,
    input  logic                   reset_n,

    // request side, from the fetch unit
    input  logic                   fetch_req,
    input  cache_pkg::word_addr_t  fetch_addr,
    output logic                   done,
    output mem_pkg::mem_word_t     rd_data,

    // memory side
    output logic                   mem_rd,
    output mem_pkg::mem_addr_t     mem_addr,
    input  logic                   mem_valid,
    input  mem_pkg::mem_word_t     mem_data,

    // observation pulses
    output logic                   hit,
    output logic                   miss
);

    // address split of the current request
    cache_pkg::tag_t         req_tag;
    cache_pkg::set_idx_t     req_set;
    cache_pkg::offset_t      req_off;

    // one entry per word, indexed by set then offset
    cache_pkg::line_t        lines [`NUM_SETS][`BLOCK_WORDS];
    cache_pkg::line_t        cur_line;
    logic                    line_hit;

    cache_pkg::fill_state_t  state;
    cache_pkg::fill_state_t  cur_phase;

    // fill progress
    cache_pkg::offset_t      fill_off;
    logic                    rd_pending;
    logic                    fill_last;

    assign {req_tag, req_set, req_off} = fetch_addr;

    assign cur_line = lines[req_set][req_off];
    assign line_hit = cur_line.valid && (cur_line.tag == req_tag);

    // the lookup phase is the idle cycle in which a request is seen
    always_comb begin
        if (state == cache_pkg::idle && fetch_req) begin
            cur_phase = cache_pkg::lookup;
        end else begin
            cur_phase = state;
        end
    end

    assign hit  = (cur_phase == cache_pkg::lookup) && line_hit;
    assign miss = (cur_phase == cache_pkg::lookup) && !line_hit;

    // answer always comes from the array, also right after a fill
    assign done    = (state == cache_pkg::respond);
    assign rd_data = cur_line.word;

    // one strobe per word, next one only after the previous valid
    assign mem_rd   = (state == cache_pkg::fill) && !rd_pending;
    assign mem_addr = {req_tag, req_set, fill_off};

    assign fill_last = (fill_off == cache_pkg::offset_t'(`BLOCK_WORDS - 1));

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state      <= cache_pkg::idle;
            fill_off   <= '0;
            rd_pending <= 1'b0;
        end else begin
            case (cur_phase)
                cache_pkg::lookup: begin
                    fill_off   <= '0;
                    rd_pending <= 1'b0;
                    if (line_hit) begin
                        state <= cache_pkg::respond;
                    end else begin
                        state <= cache_pkg::fill;
                    end
                end
                cache_pkg::fill: begin
                    if (mem_rd) begin
                        rd_pending <= 1'b1;
                    end
                    if (rd_pending && mem_valid) begin
                        rd_pending <= 1'b0;
                        fill_off   <= fill_off + 1'b1;
                        if (fill_last) begin
                            state <= cache_pkg::respond;
                        end
                    end
                end
                cache_pkg::respond: begin
                    state <= cache_pkg::idle;
                end
                default: begin
                    state <= cache_pkg::idle;
                end
            endcase
        end
    end

    // whole block is rewritten, so a different tag evicts the old block
    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int s = 0; s < `NUM_SETS; s++) begin
                for (int w = 0; w < `BLOCK_WORDS; w++) begin
                    lines[s][w].valid <= 1'b0;
                end
            end
        end else if (state == cache_pkg::fill && rd_pending && mem_valid) begin
            lines[req_set][fill_off] <= '{valid: 1'b1, tag: req_tag, word: mem_data};
        end
    end

    // fetch unit keeps the request up until the answer arrives
    done_needs_req: assert property (
        @(posedge clk) disable iff (reset_n)
        done |-> fetch_req
    );

    // a strobe lasts one cycle, the next one waits for the valid
    rd_single_pulse: assert property (
        @(posedge clk) disable iff (reset_n)
        mem_rd |=> !mem_rd
    );

    // one hit or miss per lookup
    lookup_single_pulse: assert property (
        @(posedge clk) disable iff (reset_n)
        (hit || miss) |=> !(hit || miss)
    );

endmodule

/* src/inst_mem.sv */
`timescale 1ns/10ps

`include "fetch_consts.svh"

module inst_mem (
    input  logic                 clk,
    input  logic                 reset_n,

    // program load, used while the core is held in reset
    input  logic                 prog_we,
    input  mem_pkg::load_addr_t  prog_addr,
    input  mem_pkg::mem_word_t   prog_data,

    // read port towards the cache
    input  logic                 mem_rd,
    input  mem_pkg::mem_addr_t   mem_addr,
    output logic                 mem_valid,
    output mem_pkg::mem_word_t   mem_data
);

    mem_pkg::mem_word_t   mem_array [`MEM_DEPTH];
    mem_pkg::load_addr_t  rd_index;

    // latency delay line, stage 0 holds the word read at the strobe
    logic [`MEM_LATENCY-1:0]  valid_pipe;
    mem_pkg::mem_word_t       data_pipe [`MEM_LATENCY];

    // only the low bits select a word
    assign rd_index = mem_addr[$clog2(`MEM_DEPTH)-1:0];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem_array[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`MEM_LATENCY-2:0], mem_rd};
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem_array[rd_index];
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign mem_valid = valid_pipe[`MEM_LATENCY-1];
    assign mem_data  = data_pipe[`MEM_LATENCY-1];

    // the cache waits for each valid before the next strobe
    one_read_at_a_time: assert property (
        @(posedge clk) disable iff (reset_n)
        mem_rd |-> (valid_pipe == '0)
    );

    // program load only while the fetch side is in reset
    load_in_reset_only: assert property (
        @(posedge clk)
        prog_we |-> reset_n
    );

endmodule

/* src/mem_pkg.sv */
`include "fetch_consts.svh"

package mem_pkg;

    // one word as stored in and returned by the instruction memory
    typedef logic [`WORD_SIZE-1:0] mem_word_t;

    // memory-side address, same width as a fetch address
    typedef logic [`WORD_SIZE-1:0] mem_addr_t;

    // index into the memory array, also the program-load address
    typedef logic [$clog2(`MEM_DEPTH)-1:0] load_addr_t;

endpackage

/* verilog.f */
+incdir+src
src/cache_pkg.sv
src/mem_pkg.sv
src/icache.sv
src/inst_mem.sv
src/fetch_unit.sv
src/fetch_top.sv
dv/fetch_tb.sv
